// File: bpf_params.svh
`ifndef BPF_PARAMS_SVH
`define BPF_PARAMS_SVH

// Packet memory geometry
// 4 KiB of packet storage seen by the CPU as bytes
`define BPF_BYTE_ADDR_W 12
// 512 words of 8 bytes each
`define BPF_WORD_ADDR_W 9
`define BPF_WORD_BYTES 8

// Byte length reported to CPU and forward port
`define BPF_PLEN_W 32

// Extra pipeline registers around the packet RAM
// Read latency is 1 + BUF_IN + BUF_OUT
`define BPF_MEM_BUF_IN 0
`define BPF_MEM_BUF_OUT 1

// Registered CPU read data in the adapter
`define BPF_ADAPTER_PESS 1

`endif

// File: bpf_cpu_pkg.sv
`default_nettype none

`include "bpf_params.svh"

package bpf_cpu_pkg;

    // Transfer size, classic filter encoding of the size field
    typedef enum logic [1:0] {
        XFER_W = 2'b00,
        XFER_H = 2'b01,
        XFER_B = 2'b10
    } xfer_sz_t;

    // Filter decision for the current packet
    typedef enum logic {
        VERDICT_REJ = 1'b0,
        VERDICT_ACC = 1'b1
    } verdict_t;

    typedef logic [`BPF_BYTE_ADDR_W-1:0] byte_addr_t;
    typedef logic [31:0] cpu_data_t;

endpackage

`default_nettype wire

// File: pkt_buf_pkg.sv
`default_nettype none

`include "bpf_params.svh"

package pkt_buf_pkg;

    // One packet memory word, byte 0 in the top bits
    typedef logic [8*`BPF_WORD_BYTES-1:0] mem_word_t;
    typedef logic [`BPF_WORD_ADDR_W-1:0] word_addr_t;
    typedef logic [`BPF_PLEN_W-1:0] plen_t;

    // Buffer ownership
    // Ingress fills, CPU inspects, forward port reports
    typedef enum logic [1:0] {
        BUF_FILL = 2'd0,
        BUF_CPU = 2'd1,
        BUF_FWD = 2'd2
    } buf_state_t;

endpackage

`default_nettype wire

// File: pkt_rd_if.sv
`timescale 1ns/1ps
`default_nettype none

// Word read channel between CPU adapter and packet memory
// No back-pressure, data comes back a fixed number of cycles later
interface pkt_rd_if;

    pkt_buf_pkg::word_addr_t word_addr;
    logic rd_en;
    pkt_buf_pkg::mem_word_t rd_data;

    // Requesting side
    modport reader (
        output word_addr,
        output rd_en,
        input rd_data
    );

    // Memory side
    modport mem (
        input word_addr,
        input rd_en,
        output rd_data
    );

endinterface

`default_nettype wire

// File: pkt_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpf_params.svh"

module pkt_mem (
    input wire clk,
    input wire rst,
    // Ingress write port
    input wire wr_en_i,
    input wire pkt_buf_pkg::word_addr_t wr_addr_i,
    input wire pkt_buf_pkg::mem_word_t wr_data_i,
    // Read port
    pkt_rd_if.mem rd
);

    localparam int DEPTH = 2 ** `BPF_WORD_ADDR_W;

    pkt_buf_pkg::mem_word_t ram [DEPTH];

    // Read request after the optional input stage
    pkt_buf_pkg::word_addr_t addr_s;
    logic en_s;

    // RAM read register and its valid
    pkt_buf_pkg::mem_word_t ram_q;
    logic ram_vld;

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            ram[wr_addr_i] <= wr_data_i;
        end
    end

    generate
        if (`BPF_MEM_BUF_IN != 0) begin : g_in_reg
            pkt_buf_pkg::word_addr_t addr_q;
            logic en_q;

            always_ff @(posedge clk) begin
                addr_q <= rd.word_addr;
            end

            always_ff @(posedge clk) begin
                if (!rst) begin
                    en_q <= 1'b0;
                end else begin
                    en_q <= rd.rd_en;
                end
            end

            assign addr_s = addr_q;
            assign en_s = en_q;
        end else begin : g_in_direct
            assign addr_s = rd.word_addr;
            assign en_s = rd.rd_en;
        end
    endgenerate

    // Registered read, only on request
    always_ff @(posedge clk) begin
        if (en_s) begin
            ram_q <= ram[addr_s];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ram_vld <= 1'b0;
        end else begin
            ram_vld <= en_s;
        end
    end

    generate
        if (`BPF_MEM_BUF_OUT != 0) begin : g_out_reg
            pkt_buf_pkg::mem_word_t out_q;

            // Hold the last word between reads
            always_ff @(posedge clk) begin
                if (ram_vld) begin
                    out_q <= ram_q;
                end
            end

            assign rd.rd_data = out_q;
        end else begin : g_out_direct
            assign rd.rd_data = ram_q;
        end
    endgenerate

endmodule

`default_nettype wire

// File: pkt_buf_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpf_params.svh"

module pkt_buf_ctrl (
    input wire clk,
    input wire rst,
    // Ingress handshake
    input wire in_valid_i,
    output logic in_ready_o,
    input wire in_last_i,
    input wire [$clog2(`BPF_WORD_BYTES):0] in_bytes_i,
    // Memory write addressing
    output logic wr_en_o,
    output pkt_buf_pkg::word_addr_t wr_addr_o,
    // CPU side
    output logic pkt_rdy_o,
    output pkt_buf_pkg::plen_t cpu_len_o,
    input wire cpu_verdict_valid_i,
    input wire bpf_cpu_pkg::verdict_t cpu_verdict_i,
    // Forward report
    output logic fwd_valid_o,
    output logic fwd_accept_o,
    output pkt_buf_pkg::plen_t fwd_len_o,
    input wire fwd_ready_i
);

    pkt_buf_pkg::buf_state_t state_q;
    pkt_buf_pkg::word_addr_t wr_addr_q;
    pkt_buf_pkg::plen_t len_q;
    bpf_cpu_pkg::verdict_t verdict_q;
    logic beat;

    // Ingress owns the buffer only while filling
    assign in_ready_o = (state_q == pkt_buf_pkg::BUF_FILL);
    assign beat = in_valid_i && in_ready_o;

    // Each accepted beat lands in the next word
    assign wr_en_o = beat;
    assign wr_addr_o = wr_addr_q;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= pkt_buf_pkg::BUF_FILL;
            wr_addr_q <= '0;
            len_q <= '0;
        end else begin
            case (state_q)
                pkt_buf_pkg::BUF_FILL: begin
                    if (beat) begin
                        if (in_last_i) begin
                            // Partial last beat, in_bytes_i is 1..8
                            len_q <= len_q + pkt_buf_pkg::plen_t'(in_bytes_i);
                            wr_addr_q <= '0;
                            state_q <= pkt_buf_pkg::BUF_CPU;
                        end else begin
                            len_q <= len_q + pkt_buf_pkg::plen_t'(`BPF_WORD_BYTES);
                            wr_addr_q <= wr_addr_q + 1'b1;
                        end
                    end
                end
                pkt_buf_pkg::BUF_CPU: begin
                    if (cpu_verdict_valid_i) begin
                        state_q <= pkt_buf_pkg::BUF_FWD;
                    end
                end
                pkt_buf_pkg::BUF_FWD: begin
                    // Buffer free again once the report is taken
                    if (fwd_ready_i) begin
                        len_q <= '0;
                        state_q <= pkt_buf_pkg::BUF_FILL;
                    end
                end
                default: state_q <= pkt_buf_pkg::BUF_FILL;
            endcase
        end
    end

    // Verdict kept for the forward report
    always_ff @(posedge clk) begin
        if (state_q == pkt_buf_pkg::BUF_CPU && cpu_verdict_valid_i) begin
            verdict_q <= cpu_verdict_i;
        end
    end

    assign pkt_rdy_o = (state_q == pkt_buf_pkg::BUF_CPU);
    assign cpu_len_o = len_q;

    assign fwd_valid_o = (state_q == pkt_buf_pkg::BUF_FWD);
    assign fwd_accept_o = (verdict_q == bpf_cpu_pkg::VERDICT_ACC);
    assign fwd_len_o = len_q;

endmodule

`default_nettype wire

// File: cpu_adapter.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpf_params.svh"

module cpu_adapter (
    input wire clk,
    input wire rst,
    // CPU read request
    input wire cpu_rd_en_i,
    input wire bpf_cpu_pkg::byte_addr_t cpu_addr_i,
    input wire bpf_cpu_pkg::xfer_sz_t cpu_sz_i,
    // CPU read response, L cycles after the request
    output logic cpu_data_valid_o,
    output bpf_cpu_pkg::cpu_data_t cpu_data_o,
    // Word reads to packet memory
    pkt_rd_if.reader rd
);

    localparam int MEM_LAT = 1 + `BPF_MEM_BUF_IN + `BPF_MEM_BUF_OUT;
    // Byte offset bits inside one memory word
    localparam int OFF_W = $clog2(`BPF_WORD_BYTES);

    // Request info delayed to line up with returned word
    logic [OFF_W-1:0] off_sr [MEM_LAT];
    bpf_cpu_pkg::xfer_sz_t sz_sr [MEM_LAT];
    logic [MEM_LAT-1:0] vld_sr;

    logic [OFF_W-1:0] off_d;
    bpf_cpu_pkg::xfer_sz_t sz_d;
    logic vld_d;

    pkt_buf_pkg::mem_word_t shifted;
    bpf_cpu_pkg::cpu_data_t selected;
    bpf_cpu_pkg::cpu_data_t resized;

    // Word address is the byte address minus its offset bits
    assign rd.word_addr = cpu_addr_i[`BPF_BYTE_ADDR_W-1:OFF_W];
    assign rd.rd_en = cpu_rd_en_i;

    always_ff @(posedge clk) begin
        off_sr[0] <= cpu_addr_i[OFF_W-1:0];
        sz_sr[0] <= cpu_sz_i;
        for (int i = 1; i < MEM_LAT; i++) begin
            off_sr[i] <= off_sr[i-1];
            sz_sr[i] <= sz_sr[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= (vld_sr << 1) | MEM_LAT'(cpu_rd_en_i);
        end
    end

    assign off_d = off_sr[MEM_LAT-1];
    assign sz_d = sz_sr[MEM_LAT-1];
    assign vld_d = vld_sr[MEM_LAT-1];

    // Big-endian, move requested byte to the top of the word
    // Reads never cross a word, so the top 32 bits hold the window
    assign shifted = rd.rd_data << (8 * off_d);
    assign selected = shifted[8*`BPF_WORD_BYTES-1 -: 32];

    // Smaller sizes are right-aligned and zero-padded on the left
    always_comb begin
        case (sz_d)
            bpf_cpu_pkg::XFER_W: resized = selected;
            bpf_cpu_pkg::XFER_H: resized = {16'h0000, selected[31:16]};
            bpf_cpu_pkg::XFER_B: resized = {24'h000000, selected[31:24]};
            default: resized = '0;
        endcase
    end

    generate
        if (`BPF_ADAPTER_PESS != 0) begin : g_pess
            bpf_cpu_pkg::cpu_data_t data_q;
            logic valid_q;

            always_ff @(posedge clk) begin
                data_q <= resized;
            end

            always_ff @(posedge clk) begin
                if (!rst) begin
                    valid_q <= 1'b0;
                end else begin
                    valid_q <= vld_d;
                end
            end

            assign cpu_data_o = data_q;
            assign cpu_data_valid_o = valid_q;
        end else begin : g_comb
            assign cpu_data_o = resized;
            assign cpu_data_valid_o = vld_d;
        end
    endgenerate

endmodule

`default_nettype wire

// File: pkt_read_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpf_params.svh"

module pkt_read_top (
    input wire clk,
    input wire rst,
    // Ingress port
    input wire in_valid_i,
    output logic in_ready_o,
    input wire pkt_buf_pkg::mem_word_t in_data_i,
    input wire in_last_i,
    input wire [$clog2(`BPF_WORD_BYTES):0] in_bytes_i,
    // CPU port
    output logic pkt_rdy_o,
    output pkt_buf_pkg::plen_t cpu_len_o,
    input wire cpu_rd_en_i,
    input wire bpf_cpu_pkg::byte_addr_t cpu_addr_i,
    input wire bpf_cpu_pkg::xfer_sz_t cpu_sz_i,
    output logic cpu_data_valid_o,
    output bpf_cpu_pkg::cpu_data_t cpu_data_o,
    input wire cpu_verdict_valid_i,
    input wire bpf_cpu_pkg::verdict_t cpu_verdict_i,
    // Forward port
    output logic fwd_valid_o,
    output logic fwd_accept_o,
    output pkt_buf_pkg::plen_t fwd_len_o,
    input wire fwd_ready_i
);

    // Ingress writes into the packet memory
    logic wr_en;
    pkt_buf_pkg::word_addr_t wr_addr;

    // Adapter to memory read channel
    pkt_rd_if rd_bus ();

    pkt_buf_ctrl u_ctrl (
        .clk(clk),
        .rst(rst),
        .in_valid_i(in_valid_i),
        .in_ready_o(in_ready_o),
        .in_last_i(in_last_i),
        .in_bytes_i(in_bytes_i),
        .wr_en_o(wr_en),
        .wr_addr_o(wr_addr),
        .pkt_rdy_o(pkt_rdy_o),
        .cpu_len_o(cpu_len_o),
        .cpu_verdict_valid_i(cpu_verdict_valid_i),
        .cpu_verdict_i(cpu_verdict_i),
        .fwd_valid_o(fwd_valid_o),
        .fwd_accept_o(fwd_accept_o),
        .fwd_len_o(fwd_len_o),
        .fwd_ready_i(fwd_ready_i)
    );

    // Beat data goes straight to the RAM at the controller's address
    pkt_mem u_mem (
        .clk(clk),
        .rst(rst),
        .wr_en_i(wr_en),
        .wr_addr_i(wr_addr),
        .wr_data_i(in_data_i),
        .rd(rd_bus.mem)
    );

    cpu_adapter u_adapter (
        .clk(clk),
        .rst(rst),
        .cpu_rd_en_i(cpu_rd_en_i),
        .cpu_addr_i(cpu_addr_i),
        .cpu_sz_i(cpu_sz_i),
        .cpu_data_valid_o(cpu_data_valid_o),
        .cpu_data_o(cpu_data_o),
        .rd(rd_bus.reader)
    );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and active-low reset for the testbench
module tb_clk_gen #(
    parameter int HALF_PERIOD_NS = 10,
    parameter int RST_CYCLES = 5
) (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
    end

    // Release lands just after an edge, like the other driven inputs
    initial begin
        rst_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2;
        rst_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_pkt_read.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpf_params.svh"

module tb_pkt_read;

    // Request to data latency of the CPU read path
    localparam int READ_LAT = 1 + `BPF_MEM_BUF_IN + `BPF_MEM_BUF_OUT + `BPF_ADAPTER_PESS;
    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;
    logic in_valid_i;
    logic in_ready_o;
    pkt_buf_pkg::mem_word_t in_data_i;
    logic in_last_i;
    logic [3:0] in_bytes_i;
    logic pkt_rdy_o;
    pkt_buf_pkg::plen_t cpu_len_o;
    logic cpu_rd_en_i;
    bpf_cpu_pkg::byte_addr_t cpu_addr_i;
    bpf_cpu_pkg::xfer_sz_t cpu_sz_i;
    logic cpu_data_valid_o;
    bpf_cpu_pkg::cpu_data_t cpu_data_o;
    logic cpu_verdict_valid_i;
    bpf_cpu_pkg::verdict_t cpu_verdict_i;
    logic fwd_valid_o;
    logic fwd_accept_o;
    pkt_buf_pkg::plen_t fwd_len_o;
    logic fwd_ready_i;

    int seed = 32'h232705fd;
    // Current packet bytes and its expected length
    logic [7:0] pkt_q [$];
    pkt_buf_pkg::plen_t cur_len;
    // Reads waiting to be issued as one burst
    bpf_cpu_pkg::byte_addr_t rd_addr_q [$];
    bpf_cpu_pkg::xfer_sz_t rd_sz_q [$];
    bpf_cpu_pkg::cpu_data_t rd_exp_q [$];

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

    pkt_read_top UUT (.*);

    task automatic stop_on_error();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        stop_on_error();
    endtask

    task automatic check_data(input bpf_cpu_pkg::cpu_data_t got,
                              input bpf_cpu_pkg::cpu_data_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_len(input pkt_buf_pkg::plen_t got,
                             input pkt_buf_pkg::plen_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_verdict(input bpf_cpu_pkg::verdict_t got,
                                 input bpf_cpu_pkg::verdict_t exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
            stop_on_error();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            stop_on_error();
        end
    endtask

    // Move to 2 ns after the next rising edge where inputs change
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // Beats are big-endian words
    // Idle gaps drawn from the seed
    task automatic send_packet();
        int beats;
        int last_bytes;
        int gap;
        int cnt;
        pkt_buf_pkg::mem_word_t word;
        beats = (pkt_q.size() + 7) / 8;
        last_bytes = pkt_q.size() - 8 * (beats - 1);
        step();
        for (int b = 0; b < beats; b++) begin
            word = '0;
            for (int k = 0; k < 8; k++) begin
                if (8 * b + k < pkt_q.size()) begin
                    word[63 - 8 * k -: 8] = pkt_q[8 * b + k];
                end
            end
            gap = $random(seed) & 3;
            if (gap != 0) begin
                in_valid_i = 1'b0;
                repeat (gap) step();
            end
            in_valid_i = 1'b1;
            in_data_i = word;
            in_last_i = (b == beats - 1);
            in_bytes_i = (b == beats - 1) ? 4'(last_bytes) : 4'd8;
            cnt = 0;
            @(negedge clk);
            while (!in_ready_o) begin
                cnt++;
                if (cnt > TIMEOUT) report_timeout("ingress ready");
                step();
                @(negedge clk);
            end
            // Beat taken on this edge
            step();
        end
        in_valid_i = 1'b0;
        in_last_i = 1'b0;
        cur_len = pkt_buf_pkg::plen_t'(8 * (beats - 1) + last_bytes);
        // CPU owns the buffer one cycle after the last beat
        @(negedge clk);
        check_flag(pkt_rdy_o, 1'b1, "pkt_rdy_o after last beat");
        check_flag(in_ready_o, 1'b0, "in_ready_o while CPU owns buffer");
        check_len(cpu_len_o, cur_len, "cpu_len_o");
    endtask

    // One request per cycle
    // Each answer expected READ_LAT cycles later
    task automatic issue_reads();
        int n;
        n = rd_addr_q.size();
        for (int c = 0; c < n + READ_LAT + 1; c++) begin
            step();
            cpu_rd_en_i = (c < n);
            if (c < n) begin
                cpu_addr_i = rd_addr_q[c];
                cpu_sz_i = rd_sz_q[c];
            end
            @(negedge clk);
            check_flag(in_ready_o, 1'b0, "in_ready_o while CPU owns buffer");
            if (c >= READ_LAT && c - READ_LAT < n) begin
                check_flag(cpu_data_valid_o, 1'b1, "cpu_data_valid_o at read latency");
                check_data(cpu_data_o, rd_exp_q[c - READ_LAT], "cpu_data_o");
            end else begin
                check_flag(cpu_data_valid_o, 1'b0, "cpu_data_valid_o between reads");
            end
        end
        rd_addr_q.delete();
        rd_sz_q.delete();
        rd_exp_q.delete();
    endtask

    task automatic check_forward(input bpf_cpu_pkg::verdict_t v);
        check_flag(fwd_valid_o, 1'b1, "fwd_valid_o");
        check_verdict(bpf_cpu_pkg::verdict_t'(fwd_accept_o), v, "fwd_accept_o");
        check_len(fwd_len_o, cur_len, "fwd_len_o");
        check_flag(in_ready_o, 1'b0, "in_ready_o while report waits");
    endtask

    // Verdict pulse and then a report that holds until fwd_ready_i
    task automatic give_verdict(input bpf_cpu_pkg::verdict_t v);
        int gap;
        step();
        cpu_verdict_valid_i = 1'b1;
        cpu_verdict_i = v;
        step();
        cpu_verdict_valid_i = 1'b0;
        // Report is up the cycle after the verdict
        @(negedge clk);
        gap = $random(seed) & 3;
        repeat (gap) begin
            check_forward(v);
            step();
            @(negedge clk);
        end
        check_forward(v);
        step();
        fwd_ready_i = 1'b1;
        @(negedge clk);
        check_forward(v);
        step();
        fwd_ready_i = 1'b0;
        @(negedge clk);
        check_flag(fwd_valid_o, 1'b0, "fwd_valid_o after handshake");
        check_flag(in_ready_o, 1'b1, "in_ready_o after buffer release");
    endtask

    function automatic bpf_cpu_pkg::xfer_sz_t size_from_letter(input logic [63:0] t);
        if (t == "W") return bpf_cpu_pkg::XFER_W;
        if (t == "H") return bpf_cpu_pkg::XFER_H;
        return bpf_cpu_pkg::XFER_B;
    endfunction

    initial begin
        int fd;
        int code;
        int nbytes;
        int cnt;
        int done;
        logic [63:0] tok;
        logic [63:0] arg;
        logic [7:0] b;
        logic [8*128-1:0] line;
        bpf_cpu_pkg::byte_addr_t addr;
        bpf_cpu_pkg::cpu_data_t exp;
        in_valid_i = 1'b0;
        in_data_i = '0;
        in_last_i = 1'b0;
        in_bytes_i = '0;
        cpu_rd_en_i = 1'b0;
        cpu_addr_i = '0;
        cpu_sz_i = bpf_cpu_pkg::XFER_W;
        cpu_verdict_valid_i = 1'b0;
        cpu_verdict_i = bpf_cpu_pkg::VERDICT_REJ;
        fwd_ready_i = 1'b0;
        cur_len = '0;
        cnt = 0;
        @(negedge clk);
        while (!rst) begin
            cnt++;
            if (cnt > TIMEOUT) report_timeout("reset release");
            @(negedge clk);
        end
        check_flag(in_ready_o, 1'b1, "in_ready_o after reset");
        check_flag(pkt_rdy_o, 1'b0, "pkt_rdy_o after reset");
        check_flag(fwd_valid_o, 1'b0, "fwd_valid_o after reset");
        check_flag(cpu_data_valid_o, 1'b0, "cpu_data_valid_o after reset");
        fd = $fopen("pkt_read_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file pkt_read_input.txt");
            stop_on_error();
        end
        done = 0;
        while (done == 0) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                done = 1;
            end else if (tok == "#") begin
                code = $fgets(line, fd);
            end else if (tok == "P") begin
                code = $fscanf(fd, "%d", nbytes);
                pkt_q.delete();
                for (int i = 0; i < nbytes; i++) begin
                    code = $fscanf(fd, "%h", b);
                    pkt_q.push_back(b);
                end
                send_packet();
            end else if (tok == "R") begin
                code = $fscanf(fd, "%h %s %h", addr, arg, exp);
                rd_addr_q.push_back(addr);
                rd_sz_q.push_back(size_from_letter(arg));
                rd_exp_q.push_back(exp);
            end else if (tok == "F") begin
                issue_reads();
            end else if (tok == "V") begin
                code = $fscanf(fd, "%s", arg);
                give_verdict((arg == "A") ? bpf_cpu_pkg::VERDICT_ACC : bpf_cpu_pkg::VERDICT_REJ);
            end else begin
                $display("Unknown line type in the stimulus file");
                stop_on_error();
            end
        end
        $fclose(fd);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: pkt_read_input.txt
# P <byte count> <bytes in hex>, R <byte addr> <W|H|B> <expected data>
# F issues the queued reads back to back, V <A|R> gives the verdict
P 21 45 00 00 54 a1 b2 40 00 40 01 c3 d4 0a 00 00 01 0a 00 00 02 ff
R 000 W 45000054
F
R 004 W a1b24000
R 002 H 00000054
R 006 H 00004000
R 009 B 00000001
R 00b B 000000d4
R 00c W 0a000001
R 00a H 0000c3d4
R 010 W 0a000002
R 014 B 000000ff
R 003 W 54a1b240
F
V A
P 13 11 22 33 44 55 66 77 88 99 aa bb cc dd
R 000 B 00000011
R 001 H 00002233
R 004 W 55667788
R 008 W 99aabbcc
R 00c B 000000dd
R 009 H 0000aabb
F
V R
P 8 de ad be ef 01 02 03 04
R 004 W 01020304
F
R 000 H 0000dead
R 007 B 00000004
F
V A

// File: pkt_read_top.f
+incdir+.
bpf_cpu_pkg.sv
pkt_buf_pkg.sv
pkt_rd_if.sv
pkt_mem.sv
pkt_buf_ctrl.sv
cpu_adapter.sv
pkt_read_top.sv
tb_clk_gen.sv
tb_pkt_read.sv

// File: Makefile
SIM      := verilator
TOP      := tb_pkt_read
FILELIST := pkt_read_top.f
FLAGS    := --binary --timing -Wno-fatal --top-module $(TOP)
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
PASS_MSG := Simulation passed

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) bpf_params.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN) pkt_read_input.txt
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
